// File: all.f
+incdir+.
core_pkg.sv
reg_file.sv
exu.sv
lsu.sv
wbu.sv
backend_top.sv
tb_checker.sv
tb_backend.sv

// File: backend_top.sv
`timescale 1ns/1ps

module backend_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  core_pkg::alu_op_t   alu_op,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                use_imm,
    input  core_pkg::word_t     imm,
    input  logic                mem_write,
    input  core_pkg::wb_sel_t   wb_sel,
    input  core_pkg::reg_addr_t rd,
    output logic                commit_valid,
    input  logic                commit_ready,
    output logic                wb_we,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data,
    input  core_pkg::reg_addr_t dbg_addr,
    output core_pkg::word_t     dbg_data
);
    import core_pkg::*;

    word_t     rs1_data;
    word_t     rs2_data;

    logic      ex_valid;
    logic      ex_ready;
    word_t     ex_alu_res;
    word_t     ex_store_data;
    logic      ex_mem_write;
    wb_sel_t   ex_wb_sel;
    reg_addr_t ex_rd;

    logic      ls_valid;
    logic      ls_ready;
    word_t     ls_alu_res;
    word_t     ls_mem_rdata;
    wb_sel_t   ls_wb_sel;
    reg_addr_t ls_rd;

    // ====================
    // register file
    // ====================

    reg_file u_reg_file (
        .clock    (clock),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (wb_we),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    // ====================
    // pipeline stages
    // ====================

    exu u_exu (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .alu_op        (alu_op),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .use_imm       (use_imm),
        .imm           (imm),
        .mem_write     (mem_write),
        .wb_sel        (wb_sel),
        .rd            (rd),
        .ex_valid      (ex_valid),
        .ex_ready      (ex_ready),
        .ex_alu_res    (ex_alu_res),
        .ex_store_data (ex_store_data),
        .ex_mem_write  (ex_mem_write),
        .ex_wb_sel     (ex_wb_sel),
        .ex_rd         (ex_rd)
    );

    lsu u_lsu (
        .clock         (clock),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_ready      (ex_ready),
        .ex_alu_res    (ex_alu_res),
        .ex_store_data (ex_store_data),
        .ex_mem_write  (ex_mem_write),
        .ex_wb_sel     (ex_wb_sel),
        .ex_rd         (ex_rd),
        .ls_valid      (ls_valid),
        .ls_ready      (ls_ready),
        .ls_alu_res    (ls_alu_res),
        .ls_mem_rdata  (ls_mem_rdata),
        .ls_wb_sel     (ls_wb_sel),
        .ls_rd         (ls_rd)
    );

    wbu u_wbu (
        .clock        (clock),
        .reset        (reset),
        .ls_valid     (ls_valid),
        .ls_ready     (ls_ready),
        .ls_alu_res   (ls_alu_res),
        .ls_mem_rdata (ls_mem_rdata),
        .ls_wb_sel    (ls_wb_sel),
        .ls_rd        (ls_rd),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready)
    );

endmodule

// File: core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ====================
// datapath widths
// ====================

`define XLEN        32
`define REG_ADDR_W  5

// ====================
// data memory
// ====================

`define DMEM_DEPTH  16
`define DMEM_ADDR_W 4    // word index, address bits 5:2.

`endif

// File: core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]        word_t;
    typedef logic [`REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`DMEM_ADDR_W-1:0] dmem_addr_t;

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;
    localparam alu_op_t ALU_SLT = 3'd7;

    typedef logic [1:0] wb_sel_t;    // { mem, alu }.

    localparam wb_sel_t WB_NONE = 2'b00;
    localparam wb_sel_t WB_ALU  = 2'b01;
    localparam wb_sel_t WB_MEM  = 2'b10;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_READ,
        LSU_HOLD
    } lsu_state_t;

    typedef enum logic [1:0] {
        WBU_RST,
        WBU_IDLE,
        WBU_WAIT
    } wbu_state_t;

endpackage

// File: exu.sv
`timescale 1ns/1ps

module exu (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  core_pkg::alu_op_t   alu_op,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    input  logic                use_imm,
    input  core_pkg::word_t     imm,
    input  logic                mem_write,
    input  core_pkg::wb_sel_t   wb_sel,
    input  core_pkg::reg_addr_t rd,
    output logic                ex_valid,
    input  logic                ex_ready,
    output core_pkg::word_t     ex_alu_res,
    output core_pkg::word_t     ex_store_data,
    output logic                ex_mem_write,
    output core_pkg::wb_sel_t   ex_wb_sel,
    output core_pkg::reg_addr_t ex_rd
);
    import core_pkg::*;

    word_t op_b;
    word_t alu_res;
    logic  started;
    logic  accept;
    logic  leave;

    // ====================
    // alu
    // ====================

    assign op_b = use_imm ? imm : rs2_data;

    always_comb begin
        unique case (alu_op)
            ALU_ADD: alu_res = rs1_data + op_b;
            ALU_SUB: alu_res = rs1_data - op_b;
            ALU_AND: alu_res = rs1_data & op_b;
            ALU_OR:  alu_res = rs1_data | op_b;
            ALU_XOR: alu_res = rs1_data ^ op_b;
            ALU_SLL: alu_res = rs1_data << op_b[4:0];
            ALU_SRL: alu_res = rs1_data >> op_b[4:0];
            ALU_SLT: alu_res = word_t'($signed(rs1_data) < $signed(op_b));    // signed compare.
        endcase
    end

    // ====================
    // one-entry stage
    // ====================

    assign leave    = ex_valid && ex_ready;
    assign in_ready = started && (!ex_valid || ex_ready);    // refill while draining.
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            started  <= 1'b0;
            ex_valid <= 1'b0;
        end
        else begin
            started <= 1'b1;
            if (accept) begin
                ex_valid <= 1'b1;
            end
            else if (leave) begin
                ex_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ex_alu_res    <= alu_res;
            ex_store_data <= rs2_data;    // stores always take rs2.
            ex_mem_write  <= mem_write;
            ex_wb_sel     <= wb_sel;
            ex_rd         <= rd;
        end
    end

endmodule

// File: lsu.sv
`timescale 1ns/1ps

`include "core_defines.svh"

module lsu (
    input  logic                clock,
    input  logic                reset,
    input  logic                ex_valid,
    output logic                ex_ready,
    input  core_pkg::word_t     ex_alu_res,
    input  core_pkg::word_t     ex_store_data,
    input  logic                ex_mem_write,
    input  core_pkg::wb_sel_t   ex_wb_sel,
    input  core_pkg::reg_addr_t ex_rd,
    output logic                ls_valid,
    input  logic                ls_ready,
    output core_pkg::word_t     ls_alu_res,
    output core_pkg::word_t     ls_mem_rdata,
    output core_pkg::wb_sel_t   ls_wb_sel,
    output core_pkg::reg_addr_t ls_rd
);
    import core_pkg::*;

    lsu_state_t state;
    lsu_state_t state_next;
    word_t      mem [`DMEM_DEPTH];
    dmem_addr_t addr;
    dmem_addr_t addr_q;
    logic       accept;
    logic       is_load;

    assign ex_ready = state == LSU_IDLE;
    assign ls_valid = state == LSU_HOLD;
    assign accept   = ex_valid && ex_ready;
    assign is_load  = ex_wb_sel == WB_MEM;
    assign addr     = ex_alu_res[`DMEM_ADDR_W+1:2];    // word address.

    // ====================
    // fsm
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= LSU_IDLE;
        end
        else begin
            state <= state_next;
        end
    end

    always_comb begin
        unique case (state)
            LSU_IDLE: begin
                if (accept)
                    state_next = is_load ? LSU_READ : LSU_HOLD;
                else
                    state_next = LSU_IDLE;
            end
            LSU_READ:
                state_next = LSU_HOLD;    // registered read lands here.
            LSU_HOLD:
                state_next = ls_ready ? LSU_IDLE : LSU_HOLD;
            default:
                state_next = LSU_IDLE;
        endcase
    end

    // ====================
    // data memory
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end
        else if (accept && ex_mem_write) begin
            mem[addr] <= ex_store_data;
        end
    end

    always_ff @(posedge clock) begin
        if (state == LSU_READ) begin
            ls_mem_rdata <= mem[addr_q];
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q     <= addr;
            ls_alu_res <= ex_alu_res;
            ls_wb_sel  <= ex_wb_sel;
            ls_rd      <= ex_rd;
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

`include "core_defines.svh"

module reg_file (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                we,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data,
    input  core_pkg::reg_addr_t dbg_addr,
    output core_pkg::word_t     dbg_data
);
    import core_pkg::*;

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    word_t regs [NUM_REGS];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (we && wr_addr != '0) begin    // x0 is hardwired.
            regs[wr_addr] <= wr_data;
        end
    end

    // ====================
    // read ports
    // ====================

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the back end testbench with verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module tb_backend -o tb_backend_sim

./obj_dir/tb_backend_sim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_backend.sv
`timescale 1ns/1ps

module tb_backend;
    import core_pkg::*;

    typedef struct {
        logic [95:0] name;
        alu_op_t     op;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic        use_imm;
        word_t       imm;
        logic        mem_write;
        wb_sel_t     wb_sel;
        reg_addr_t   rd;
        int          stall;    // cycles before commit_ready.
    } op_entry_t;

    logic        clock = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    alu_op_t     alu_op;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic        use_imm;
    word_t       imm;
    logic        mem_write;
    wb_sel_t     wb_sel;
    reg_addr_t   rd;
    logic        commit_valid;
    logic        commit_ready;
    logic        wb_we;
    reg_addr_t   wb_rd;
    word_t       wb_data;
    reg_addr_t   dbg_addr;
    word_t       dbg_data;
    logic        dbg_check;
    logic [95:0] test_name;
    int          error_count;
    int          test_count;
    int          fail_count;
    logic        boot_seen;

    op_entry_t   ops [$];
    logic [31:0] rng_state;
    int          max_stall;
    int          cycles = 0;
    int          cycle_limit = 1000000;

    always #50 clock = ~clock;

    backend_top uut (.*);

    tb_checker chk (.*);

    // ====================
    // timeout
    // ====================

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Error: timeout, the run hung after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_op(input logic [95:0] name, input alu_op_t op, input reg_addr_t a,
                          input reg_addr_t b, input logic use_i, input word_t value,
                          input logic store, input wb_sel_t sel, input reg_addr_t dest,
                          input int stall);
        op_entry_t e;
        e.name      = name;
        e.op        = op;
        e.rs1       = a;
        e.rs2       = b;
        e.use_imm   = use_i;
        e.imm       = value;
        e.mem_write = store;
        e.wb_sel    = sel;
        e.rd        = dest;
        e.stall     = stall;
        ops.push_back(e);
    endtask

    // ====================
    // operation table
    // ====================

    task automatic build_table();
        rng_state = 32'h6f36a661;
        rng_state = xorshift32(rng_state);
        add_op(96'("li_x1"), ALU_ADD, 5'd0, 5'd0, 1'b1, rng_state, 1'b0, WB_ALU, 5'd1, 0);
        rng_state = xorshift32(rng_state);
        add_op(96'("li_x2"), ALU_ADD, 5'd0, 5'd0, 1'b1, rng_state, 1'b0, WB_ALU, 5'd2, 1);
        rng_state = xorshift32(rng_state);
        add_op(96'("li_x3"), ALU_ADD, 5'd0, 5'd0, 1'b1, rng_state, 1'b0, WB_ALU, 5'd3, 0);
        add_op(96'("add_rr"), ALU_ADD, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd4, 0);
        add_op(96'("sub_rr"), ALU_SUB, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd5, 3);
        add_op(96'("and_rr"), ALU_AND, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd6, 0);
        add_op(96'("or_rr"), ALU_OR, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd7, 0);
        add_op(96'("xor_rr"), ALU_XOR, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd8, 1);
        add_op(96'("sll_rr"), ALU_SLL, 5'd1, 5'd3, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd9, 0);
        add_op(96'("srl_rr"), ALU_SRL, 5'd2, 5'd3, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd10, 0);
        add_op(96'("slt_rr"), ALU_SLT, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd11, 0);
        rng_state = xorshift32(rng_state);
        add_op(96'("slt_ri"), ALU_SLT, 5'd2, 5'd0, 1'b1, rng_state, 1'b0, WB_ALU, 5'd12, 0);
        rng_state = xorshift32(rng_state);
        add_op(96'("add_ri"), ALU_ADD, 5'd1, 5'd0, 1'b1, rng_state, 1'b0, WB_ALU, 5'd13, 2);
        add_op(96'("sub_ri"), ALU_SUB, 5'd2, 5'd0, 1'b1, 32'h1, 1'b0, WB_ALU, 5'd14, 0);
        add_op(96'("and_ri"), ALU_AND, 5'd1, 5'd0, 1'b1, 32'h0000ffff, 1'b0, WB_ALU, 5'd15, 0);
        add_op(96'("or_ri"), ALU_OR, 5'd2, 5'd0, 1'b1, 32'h80000000, 1'b0, WB_ALU, 5'd16, 0);
        add_op(96'("xor_ri"), ALU_XOR, 5'd1, 5'd0, 1'b1, 32'hffffffff, 1'b0, WB_ALU, 5'd17, 0);
        add_op(96'("sll_ri"), ALU_SLL, 5'd2, 5'd0, 1'b1, 32'd4, 1'b0, WB_ALU, 5'd18, 0);
        add_op(96'("srl_ri"), ALU_SRL, 5'd1, 5'd0, 1'b1, 32'd31, 1'b0, WB_ALU, 5'd19, 0);
        add_op(96'("wr_x0"), ALU_ADD, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_ALU, 5'd0, 0);
        // stores pass rd, which must be ignored.
        add_op(96'("sw_a"), ALU_ADD, 5'd0, 5'd4, 1'b1, 32'h14, 1'b1, WB_NONE, 5'd24, 4);
        add_op(96'("lw_a"), ALU_ADD, 5'd0, 5'd0, 1'b1, 32'h14, 1'b0, WB_MEM, 5'd20, 0);
        add_op(96'("lw_empty"), ALU_ADD, 5'd0, 5'd0, 1'b1, 32'h30, 1'b0, WB_MEM, 5'd21, 0);
        add_op(96'("sw_b"), ALU_ADD, 5'd0, 5'd1, 1'b1, 32'h3c, 1'b1, WB_NONE, 5'd0, 2);
        add_op(96'("lw_b"), ALU_ADD, 5'd0, 5'd0, 1'b1, 32'h3c, 1'b0, WB_MEM, 5'd22, 5);
        add_op(96'("none_op"), ALU_ADD, 5'd1, 5'd2, 1'b0, 32'h0, 1'b0, WB_NONE, 5'd23, 1);
    endtask

    // ====================
    // issue and commit
    // ====================

    task automatic take_commit(input int stall);
        while (commit_valid !== 1'b1) begin
            @(negedge clock);
        end
        repeat (stall) @(negedge clock);
        commit_ready = 1'b1;
        @(negedge clock);
        commit_ready = 1'b0;
    endtask

    task automatic issue_op(input op_entry_t e);
        test_name = e.name;
        alu_op    = e.op;
        rs1       = e.rs1;
        rs2       = e.rs2;
        use_imm   = e.use_imm;
        imm       = e.imm;
        mem_write = e.mem_write;
        wb_sel    = e.wb_sel;
        rd        = e.rd;
        in_valid  = 1'b1;
        while (in_ready !== 1'b1) begin
            @(negedge clock);
        end
        @(negedge clock);    // taken on the rising edge just passed.
        in_valid = 1'b0;
    endtask

    task automatic read_back_registers();
        dbg_check = 1'b1;
        for (int r = 0; r < 32; r++) begin
            dbg_addr = reg_addr_t'(r);
            @(negedge clock);
        end
        dbg_check = 1'b0;
        repeat (2) @(negedge clock);
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        alu_op       = ALU_ADD;
        rs1          = '0;
        rs2          = '0;
        use_imm      = 1'b0;
        imm          = '0;
        mem_write    = 1'b0;
        wb_sel       = WB_NONE;
        rd           = '0;
        commit_ready = 1'b0;
        dbg_addr     = '0;
        dbg_check    = 1'b0;
        test_name    = '0;

        build_table();
        max_stall = 0;
        foreach (ops[i]) begin
            if (ops[i].stall > max_stall) begin
                max_stall = ops[i].stall;
            end
        end
        cycle_limit = ops.size() * (8 + max_stall) + 50;

        repeat (3) @(negedge clock);
        reset = 1'b0;

        take_commit(0);    // boot token.
        foreach (ops[i]) begin
            issue_op(ops[i]);
            take_commit(ops[i].stall);
        end
        read_back_registers();

        $display("tests: %0d run, %0d failed, %0d errors", test_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0 && boot_seen === 1'b1
            && test_count == ops.size() + 1) begin
            $display("*** PASSED ***");
        end
        else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

`include "core_defines.svh"

module tb_checker (
    input  logic                clock,
    input  logic                reset,
    input  logic [95:0]         test_name,
    input  logic                in_valid,
    input  logic                in_ready,
    input  core_pkg::alu_op_t   alu_op,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  logic                use_imm,
    input  core_pkg::word_t     imm,
    input  logic                mem_write,
    input  core_pkg::wb_sel_t   wb_sel,
    input  core_pkg::reg_addr_t rd,
    input  logic                commit_valid,
    input  logic                commit_ready,
    input  logic                wb_we,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data,
    input  logic                dbg_check,
    input  core_pkg::reg_addr_t dbg_addr,
    input  core_pkg::word_t     dbg_data,
    output int                  error_count,
    output int                  test_count,
    output int                  fail_count,
    output logic                boot_seen
);
    import core_pkg::*;

    word_t       shadow_regs [32];
    word_t       shadow_mem [`DMEM_DEPTH];
    int          errors = 0;
    int          tests = 0;
    int          fails = 0;
    logic        boot_done;
    logic        pending;     // an issued operation not yet committed.
    logic        expect_we;
    logic        got_write;
    logic        test_bad;
    reg_addr_t   exp_rd;
    word_t       exp_data;
    logic [95:0] cur_name;
    logic        reset_q;
    logic        token_open;
    logic        dbg_q;
    logic        sweep_bad;

    assign error_count = errors;
    assign test_count  = tests;
    assign fail_count  = fails;
    assign boot_seen   = boot_done;

    // ====================
    // reference model
    // ====================

    function automatic word_t predict_alu(input alu_op_t op, input word_t a, input word_t b);
        word_t r;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLL: r = a << b[4:0];
            ALU_SRL: r = a >> b[4:0];
            ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        return r;
    endfunction

    task automatic record_issue();
        word_t      a;
        word_t      b;
        word_t      res;
        dmem_addr_t idx;
        a   = shadow_regs[rs1];
        b   = use_imm ? imm : shadow_regs[rs2];
        res = predict_alu(alu_op, a, b);
        idx = res[`DMEM_ADDR_W+1:2];
        if (mem_write) begin
            shadow_mem[idx] = shadow_regs[rs2];
        end
        expect_we = (wb_sel != WB_NONE);
        exp_rd    = rd;
        exp_data  = wb_sel[1] ? shadow_mem[idx] : res;
        if (expect_we && rd != '0) begin
            shadow_regs[rd] = exp_data;
        end
        cur_name  = test_name;
        pending   = 1'b1;
        got_write = 1'b0;
        test_bad  = 1'b0;
    endtask

    task automatic check_write();
        if (!pending || !expect_we || got_write) begin
            $display("Error: unexpected register write to x%0d", wb_rd);
            errors++;
            test_bad = pending;
        end
        else begin
            got_write = 1'b1;
            if (wb_rd !== exp_rd || wb_data !== exp_data) begin
                $display("Fail %0s: expected x%0d=%h, actual x%0d=%h",
                         cur_name, exp_rd, exp_data, wb_rd, wb_data);
                errors++;
                test_bad = 1'b1;
            end
        end
    endtask

    task automatic close_commit();
        if (!pending) begin
            if (!boot_done) begin
                boot_done = 1'b1;
                $display("Pass boot_token");
            end
        end
        else begin
            if (expect_we && !got_write) begin
                $display("Error: %0s committed without its register write", cur_name);
                errors++;
                test_bad = 1'b1;
            end
            tests++;
            if (test_bad) begin
                fails++;
            end
            else begin
                $display("Pass %0s", cur_name);
            end
            pending = 1'b0;
        end
    endtask

    task automatic check_debug_read();
        if (dbg_check === 1'b1 && !dbg_q) begin
            sweep_bad = 1'b0;
        end
        if (dbg_check === 1'b1 && dbg_data !== shadow_regs[dbg_addr]) begin
            $display("Fail reg_x%0d: expected %h, actual %h",
                     dbg_addr, shadow_regs[dbg_addr], dbg_data);
            errors++;
            sweep_bad = 1'b1;
        end
        if (dbg_q && dbg_check !== 1'b1) begin
            tests++;
            if (sweep_bad) begin
                fails++;
            end
            else begin
                $display("Pass register_sweep");
            end
        end
        dbg_q = (dbg_check === 1'b1);
    endtask

    // ====================
    // monitor
    // ====================

    always @(posedge clock) begin
        if (reset) begin
            if (reset_q && (in_ready !== 1'b0 || commit_valid !== 1'b0 || wb_we !== 1'b0)) begin
                $display("Error: handshake or write output active during reset");
                errors++;
            end
            for (int i = 0; i < 32; i++) begin
                shadow_regs[i] = '0;
            end
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                shadow_mem[i] = '0;
            end
            pending    = 1'b0;
            boot_done  = 1'b0;
            token_open = 1'b0;
            dbg_q      = 1'b0;
        end
        else begin
            if (wb_we === 1'b1) begin
                check_write();
            end
            if (token_open && commit_valid !== 1'b1) begin
                $display("Error: commit_valid dropped before commit_ready took it");
                errors++;
            end
            if (commit_valid === 1'b1 && !token_open && !pending && boot_done) begin
                $display("Error: commit token raised with no operation in flight");
                errors++;
            end
            if (commit_valid === 1'b1 && commit_ready === 1'b1) begin
                close_commit();
            end
            if (in_valid === 1'b1 && in_ready === 1'b1) begin
                record_issue();
            end
            check_debug_read();
            token_open = (commit_valid === 1'b1 && commit_ready !== 1'b1);    // token held.
        end
        reset_q = reset;
    end

endmodule

// File: wbu.sv
`timescale 1ns/1ps

module wbu (
    input  logic                clock,
    input  logic                reset,
    input  logic                ls_valid,
    output logic                ls_ready,
    input  core_pkg::word_t     ls_alu_res,
    input  core_pkg::word_t     ls_mem_rdata,
    input  core_pkg::wb_sel_t   ls_wb_sel,
    input  core_pkg::reg_addr_t ls_rd,
    output logic                wb_we,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data,
    output logic                commit_valid,
    input  logic                commit_ready
);
    import core_pkg::*;

    wbu_state_t state;
    wbu_state_t state_next;
    logic       accept;

    assign accept = ls_valid && ls_ready;

    // ====================
    // fsm
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= WBU_RST;
        end
        else begin
            state <= state_next;
        end
    end

    always_comb begin
        unique case (state)
            WBU_RST:  state_next = WBU_WAIT;    // boot token.
            WBU_IDLE: state_next = accept ? WBU_WAIT : WBU_IDLE;
            WBU_WAIT: state_next = commit_ready ? WBU_IDLE : WBU_WAIT;
            default:  state_next = WBU_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ls_ready     <= 1'b0;
            commit_valid <= 1'b0;
        end
        else begin
            unique case (state)
                WBU_RST: begin
                    ls_ready     <= 1'b0;
                    commit_valid <= 1'b1;
                end
                WBU_IDLE: begin
                    ls_ready     <= !accept;
                    commit_valid <= accept;
                end
                WBU_WAIT: begin
                    ls_ready     <= commit_ready;
                    commit_valid <= !commit_ready;
                end
                default: begin
                    ls_ready     <= 1'b0;
                    commit_valid <= 1'b0;
                end
            endcase
        end
    end

    // ====================
    // register write
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_we <= 1'b0;
        end
        else begin
            wb_we <= accept && (ls_wb_sel != WB_NONE);    // one-cycle pulse.
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            wb_rd   <= ls_rd;
            wb_data <= ls_wb_sel[1] ? ls_mem_rdata : ls_alu_res;
        end
    end

endmodule
